// ==== source/dcache_pkg.sv ====
/*
 data cache package
 widths, line field offsets and FSM state indices
 shared by the cache RAM, its port and the controller
*/
package dcache_pkg;

	// ==============================
	// address and bus widths
	// ==============================
	localparam int unsigned ADDR_BITS = 32;
	localparam int unsigned DATA_BITS = 32;
	// wishbone byte select width and per-byte valid mask
	localparam int unsigned SEL_BITS = 4;

	// 64 lines of one word each
	localparam int unsigned INDEX_BITS = 6;
	localparam int unsigned LINES = 1 << INDEX_BITS;
	localparam int unsigned TAG_BITS = 30 - INDEX_BITS;

	// ==============================
	// line holds dirty, tag, mask and data from msb down
	// ==============================
	localparam int unsigned DATA_LSB = 0;
	localparam int unsigned MASK_LSB = DATA_LSB + DATA_BITS;
	localparam int unsigned TAG_LSB = MASK_LSB + SEL_BITS;
	localparam int unsigned DIRTY_POS = TAG_LSB + TAG_BITS;
	localparam int unsigned LINE_BITS = DIRTY_POS + 1;

	// one-hot controller state bits
	localparam int unsigned ST_IDLE = 0;
	localparam int unsigned ST_PASS = 1;
	localparam int unsigned ST_WRITE_LOOKUP = 2;
	localparam int unsigned ST_WRITE_EVICT = 3;
	localparam int unsigned ST_READ_LOOKUP = 4;
	localparam int unsigned ST_READ_WRITEBACK = 5;
	localparam int unsigned ST_READ_REFILL = 6;
	localparam int unsigned ST_FLUSH_STEP = 7;
	localparam int unsigned ST_FLUSH_CHECK = 8;
	localparam int unsigned ST_FLUSH_WRITE = 9;
	localparam int unsigned ST_INIT = 10;
	localparam int unsigned STATE_BITS = 11;

endpackage

// ==== source/cache_ram_if.sv ====
/*
 cache RAM port
 controller presents index, write enable and line,
 RAM returns the line at last cycle's index
*/
`timescale 1ns/1ps

interface cache_ram_if;

	logic write_enable;
	logic [dcache_pkg::INDEX_BITS-1:0] index;
	logic [dcache_pkg::LINE_BITS-1:0] write_line;
	// registered and one cycle behind the index
	logic [dcache_pkg::LINE_BITS-1:0] read_line;

	modport controller (
		output write_enable,
		output index,
		output write_line,
		input read_line
	);

	modport ram (
		input write_enable,
		input index,
		input write_line,
		output read_line
	);

endinterface

// ==== source/cache_ram.sv ====
/*
 cache line store
 single port, one line per index, read data registered
 so it shows the line addressed in the previous cycle
*/
`timescale 1ns/1ps

module cache_ram (
	input logic i_clock,
	cache_ram_if.ram ram
);

	logic [dcache_pkg::LINE_BITS-1:0] lines [dcache_pkg::LINES];

	// read returns the old line on a same-cycle write
	always_ff @(posedge i_clock) begin
		if (ram.write_enable) begin
			lines[ram.index] <= ram.write_line;
		end
		ram.read_line <= lines[ram.index];
	end

	// ==============================
	// checks
	// ==============================

	// the controller steers a known index on every edge
	a_index_known: assert property (
		@(posedge i_clock)
		!$isunknown(ram.index)
	) else $error("cache_ram: unknown line index");

endmodule

// ==== source/dcache_controller.sv ====
/*
 data cache controller
 direct mapped write-back lookup, merge, eviction, refill,
 uncached pass-through, flush and line clear after reset
 wishbone classic master toward memory
*/
`timescale 1ns/1ps

module dcache_controller (
	input logic i_clock,
	input logic i_reset,

	cache_ram_if.controller ram,

	// processor side
	input logic i_request,
	input logic i_rw,
	input logic i_flush,
	input logic i_cacheable,
	input logic [dcache_pkg::ADDR_BITS-1:0] i_address,
	input logic [dcache_pkg::DATA_BITS-1:0] i_wdata,
	input logic [dcache_pkg::SEL_BITS-1:0] i_wmask,
	output logic o_ready,
	output logic [dcache_pkg::DATA_BITS-1:0] o_rdata,

	// wishbone
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic o_wb_we,
	output logic [dcache_pkg::ADDR_BITS-1:0] o_wb_adr,
	output logic [dcache_pkg::DATA_BITS-1:0] o_wb_dat,
	output logic [dcache_pkg::SEL_BITS-1:0] o_wb_sel,
	input logic [dcache_pkg::DATA_BITS-1:0] i_wb_dat,
	input logic i_wb_ack
);

	function automatic logic [dcache_pkg::STATE_BITS-1:0] onehot(input int unsigned s);
		logic [dcache_pkg::STATE_BITS-1:0] v;
		v = '0;
		v[s] = 1'b1;
		return v;
	endfunction

	// byte mask to bit mask
	function automatic logic [dcache_pkg::DATA_BITS-1:0] expand_mask(
		input logic [dcache_pkg::SEL_BITS-1:0] mask
	);
		logic [dcache_pkg::DATA_BITS-1:0] bits;
		bits = '0;
		for (int b = 0; b < dcache_pkg::SEL_BITS; b++) begin
			bits[b*8 +: 8] = {8{mask[b]}};
		end
		return bits;
	endfunction

	function automatic logic [dcache_pkg::LINE_BITS-1:0] pack_line(
		input logic dirty,
		input logic [dcache_pkg::TAG_BITS-1:0] tag,
		input logic [dcache_pkg::SEL_BITS-1:0] mask,
		input logic [dcache_pkg::DATA_BITS-1:0] data
	);
		logic [dcache_pkg::LINE_BITS-1:0] line;
		line = '0;
		line[dcache_pkg::DIRTY_POS] = dirty;
		line[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_BITS] = tag;
		line[dcache_pkg::MASK_LSB +: dcache_pkg::SEL_BITS] = mask;
		line[dcache_pkg::DATA_LSB +: dcache_pkg::DATA_BITS] = data;
		return line;
	endfunction

	logic [dcache_pkg::STATE_BITS-1:0] state;
	// walks the lines during clear and flush with the top bit as end marker
	logic [dcache_pkg::INDEX_BITS:0] line_count;
	logic ready_r;
	logic [dcache_pkg::DATA_BITS-1:0] rdata_r;

	// request fields
	logic [dcache_pkg::TAG_BITS-1:0] req_tag;
	logic [dcache_pkg::INDEX_BITS-1:0] req_index;
	assign req_tag = i_address[dcache_pkg::ADDR_BITS-1 -: dcache_pkg::TAG_BITS];
	assign req_index = i_address[2 +: dcache_pkg::INDEX_BITS];

	// stored line fields
	logic line_dirty;
	logic [dcache_pkg::TAG_BITS-1:0] line_tag;
	logic [dcache_pkg::SEL_BITS-1:0] line_mask;
	logic [dcache_pkg::DATA_BITS-1:0] line_data;
	logic [dcache_pkg::ADDR_BITS-1:0] line_address;
	assign line_dirty = ram.read_line[dcache_pkg::DIRTY_POS];
	assign line_tag = ram.read_line[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_BITS];
	assign line_mask = ram.read_line[dcache_pkg::MASK_LSB +: dcache_pkg::SEL_BITS];
	assign line_data = ram.read_line[dcache_pkg::DATA_LSB +: dcache_pkg::DATA_BITS];
	assign line_address = {line_tag, ram.index, 2'b00};

	// ==============================
	// lookup
	// ==============================
	logic line_match;
	logic read_hit;
	logic write_hit;
	logic evict;
	logic needs_writeback;
	logic bus_done;
	logic [dcache_pkg::DATA_BITS-1:0] req_mask_bits;
	logic [dcache_pkg::DATA_BITS-1:0] merged_data;

	assign line_match = line_tag == req_tag;
	assign read_hit = &line_mask && line_match;
	assign write_hit = |line_mask && line_match;
	assign needs_writeback = line_dirty && |line_mask;
	// clean lines of another tag are simply overwritten
	assign evict = needs_writeback && !line_match;
	assign bus_done = o_wb_stb && i_wb_ack;

	assign req_mask_bits = expand_mask(i_wmask);
	assign merged_data = (line_data & ~req_mask_bits) | (i_wdata & req_mask_bits);

	// flush and clear index by the counter and all else by the request
	always_comb begin
		if (state[dcache_pkg::ST_FLUSH_STEP] || state[dcache_pkg::ST_FLUSH_CHECK] ||
				state[dcache_pkg::ST_FLUSH_WRITE] || state[dcache_pkg::ST_INIT]) begin
			ram.index = line_count[dcache_pkg::INDEX_BITS-1:0];
		end
		else begin
			ram.index = req_index;
		end
	end

	// RAM writes land on the edge that completes the step
	always_comb begin
		ram.write_enable = 1'b0;
		ram.write_line = '0;
		if (state[dcache_pkg::ST_INIT]) begin
			ram.write_enable = !line_count[dcache_pkg::INDEX_BITS];
		end
		else if (state[dcache_pkg::ST_WRITE_LOOKUP]) begin
			ram.write_enable = !evict;
			if (write_hit) begin
				ram.write_line = pack_line(1'b1, req_tag, line_mask | i_wmask, merged_data);
			end
			else begin
				ram.write_line = pack_line(1'b1, req_tag, i_wmask, i_wdata);
			end
		end
		else if (state[dcache_pkg::ST_WRITE_EVICT]) begin
			ram.write_enable = bus_done;
			ram.write_line = pack_line(1'b1, req_tag, i_wmask, i_wdata);
		end
		else if (state[dcache_pkg::ST_READ_REFILL]) begin
			ram.write_enable = bus_done;
			ram.write_line = pack_line(1'b0, req_tag, '1, i_wb_dat);
		end
		else if (state[dcache_pkg::ST_FLUSH_WRITE]) begin
			// same line marked clean
			ram.write_enable = bus_done;
			ram.write_line = pack_line(1'b0, line_tag, line_mask, line_data);
		end
	end

	// hits answer in the lookup cycle itself
	assign o_ready = ready_r || (state[dcache_pkg::ST_READ_LOOKUP] && read_hit) ||
		(state[dcache_pkg::ST_WRITE_LOOKUP] && !evict);
	assign o_rdata = state[dcache_pkg::ST_READ_LOOKUP] ? line_data : rdata_r;

	// ==============================
	// state machine
	// ==============================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= onehot(dcache_pkg::ST_INIT);
			line_count <= '0;
			ready_r <= 1'b0;
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else begin
			ready_r <= 1'b0;
			unique case (1'b1)
				state[dcache_pkg::ST_IDLE]: begin
					// ready_r still high means the requester has not moved on yet
					if (i_request && !ready_r) begin
						if (i_flush) begin
							line_count <= '0;
							state <= onehot(dcache_pkg::ST_FLUSH_STEP);
						end
						else if (!i_cacheable) begin
							o_wb_cyc <= 1'b1;
							o_wb_stb <= 1'b1;
							o_wb_we <= i_rw;
							o_wb_adr <= {i_address[dcache_pkg::ADDR_BITS-1:2], 2'b00};
							o_wb_dat <= i_wdata;
							o_wb_sel <= i_rw ? i_wmask : '1;
							state <= onehot(dcache_pkg::ST_PASS);
						end
						else if (i_rw) begin
							state <= onehot(dcache_pkg::ST_WRITE_LOOKUP);
						end
						else begin
							state <= onehot(dcache_pkg::ST_READ_LOOKUP);
						end
					end
				end

				state[dcache_pkg::ST_PASS]: begin
					if (bus_done) begin
						o_wb_cyc <= 1'b0;
						o_wb_stb <= 1'b0;
						rdata_r <= i_wb_dat;
						ready_r <= 1'b1;
						state <= onehot(dcache_pkg::ST_IDLE);
					end
				end

				// ==============================
				// write
				// ==============================
				state[dcache_pkg::ST_WRITE_LOOKUP]: begin
					if (evict) begin
						// old line goes out with its own byte mask
						o_wb_cyc <= 1'b1;
						o_wb_stb <= 1'b1;
						o_wb_we <= 1'b1;
						o_wb_adr <= line_address;
						o_wb_dat <= line_data;
						o_wb_sel <= line_mask;
						state <= onehot(dcache_pkg::ST_WRITE_EVICT);
					end
					else begin
						state <= onehot(dcache_pkg::ST_IDLE);
					end
				end

				state[dcache_pkg::ST_WRITE_EVICT]: begin
					if (bus_done) begin
						o_wb_cyc <= 1'b0;
						o_wb_stb <= 1'b0;
						ready_r <= 1'b1;
						state <= onehot(dcache_pkg::ST_IDLE);
					end
				end

				// ==============================
				// read
				// ==============================
				state[dcache_pkg::ST_READ_LOOKUP]: begin
					if (read_hit) begin
						state <= onehot(dcache_pkg::ST_IDLE);
					end
					else if (needs_writeback) begin
						o_wb_cyc <= 1'b1;
						o_wb_stb <= 1'b1;
						o_wb_we <= 1'b1;
						o_wb_adr <= line_address;
						o_wb_dat <= line_data;
						o_wb_sel <= line_mask;
						state <= onehot(dcache_pkg::ST_READ_WRITEBACK);
					end
					else begin
						state <= onehot(dcache_pkg::ST_READ_REFILL);
					end
				end

				state[dcache_pkg::ST_READ_WRITEBACK]: begin
					if (bus_done) begin
						o_wb_cyc <= 1'b0;
						o_wb_stb <= 1'b0;
						state <= onehot(dcache_pkg::ST_READ_REFILL);
					end
				end

				// starts its own bus read and then waits for ack
				state[dcache_pkg::ST_READ_REFILL]: begin
					if (!o_wb_stb) begin
						o_wb_cyc <= 1'b1;
						o_wb_stb <= 1'b1;
						o_wb_we <= 1'b0;
						o_wb_adr <= {i_address[dcache_pkg::ADDR_BITS-1:2], 2'b00};
						o_wb_sel <= '1;
					end
					else if (i_wb_ack) begin
						o_wb_cyc <= 1'b0;
						o_wb_stb <= 1'b0;
						rdata_r <= i_wb_dat;
						ready_r <= 1'b1;
						state <= onehot(dcache_pkg::ST_IDLE);
					end
				end

				// ==============================
				// flush
				// ==============================
				state[dcache_pkg::ST_FLUSH_STEP]: begin
					if (line_count[dcache_pkg::INDEX_BITS]) begin
						line_count <= '0;
						ready_r <= 1'b1;
						state <= onehot(dcache_pkg::ST_IDLE);
					end
					else begin
						state <= onehot(dcache_pkg::ST_FLUSH_CHECK);
					end
				end

				state[dcache_pkg::ST_FLUSH_CHECK]: begin
					if (needs_writeback) begin
						o_wb_cyc <= 1'b1;
						o_wb_stb <= 1'b1;
						o_wb_we <= 1'b1;
						o_wb_adr <= line_address;
						o_wb_dat <= line_data;
						o_wb_sel <= line_mask;
						state <= onehot(dcache_pkg::ST_FLUSH_WRITE);
					end
					else begin
						line_count <= line_count + 1'b1;
						state <= onehot(dcache_pkg::ST_FLUSH_STEP);
					end
				end

				state[dcache_pkg::ST_FLUSH_WRITE]: begin
					if (bus_done) begin
						o_wb_cyc <= 1'b0;
						o_wb_stb <= 1'b0;
						line_count <= line_count + 1'b1;
						state <= onehot(dcache_pkg::ST_FLUSH_STEP);
					end
				end

				// clear all lines one per cycle
				state[dcache_pkg::ST_INIT]: begin
					if (line_count[dcache_pkg::INDEX_BITS]) begin
						line_count <= '0;
						state <= onehot(dcache_pkg::ST_IDLE);
					end
					else begin
						line_count <= line_count + 1'b1;
					end
				end

				default: begin
					state <= onehot(dcache_pkg::ST_IDLE);
				end
			endcase
		end
	end

	// ==============================
	// checks
	// ==============================
	a_stb_in_cyc: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_wb_stb |-> o_wb_cyc
	) else $error("dcache_controller: stb without cyc");

	// master holds everything until ack in a classic cycle
	a_wb_stable: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_wb_stb && !i_wb_ack |=>
			o_wb_stb && $stable({o_wb_we, o_wb_adr, o_wb_dat, o_wb_sel})
	) else $error("dcache_controller: wishbone outputs changed before ack");

	a_no_ready_in_init: assert property (
		@(posedge i_clock) disable iff (i_reset)
		state[dcache_pkg::ST_INIT] |-> !o_ready
	) else $error("dcache_controller: ready during line clear");

endmodule

// ==== source/dcache_top.sv ====
/*
 data cache top level
 controller plus line RAM, processor load/store port
 on one side and wishbone classic master on the other
*/
`timescale 1ns/1ps

module dcache_top (
	input logic i_clock,
	input logic i_reset,

	// processor
	input logic i_request,
	input logic i_rw,
	input logic i_flush,
	input logic i_cacheable,
	input logic [dcache_pkg::ADDR_BITS-1:0] i_address,
	input logic [dcache_pkg::DATA_BITS-1:0] i_wdata,
	input logic [dcache_pkg::SEL_BITS-1:0] i_wmask,
	output logic o_ready,
	output logic [dcache_pkg::DATA_BITS-1:0] o_rdata,

	// wishbone
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic o_wb_we,
	output logic [dcache_pkg::ADDR_BITS-1:0] o_wb_adr,
	output logic [dcache_pkg::DATA_BITS-1:0] o_wb_dat,
	output logic [dcache_pkg::SEL_BITS-1:0] o_wb_sel,
	input logic [dcache_pkg::DATA_BITS-1:0] i_wb_dat,
	input logic i_wb_ack
);

	cache_ram_if ram_bus ();

	cache_ram i_cache_ram (
		.i_clock(i_clock),
		.ram(ram_bus.ram)
	);

	dcache_controller i_dcache_controller (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.ram(ram_bus.controller),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_flush(i_flush),
		.i_cacheable(i_cacheable),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_wmask(i_wmask),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb),
		.o_wb_we(o_wb_we),
		.o_wb_adr(o_wb_adr),
		.o_wb_dat(o_wb_dat),
		.o_wb_sel(o_wb_sel),
		.i_wb_dat(i_wb_dat),
		.i_wb_ack(i_wb_ack)
	);

endmodule

// ==== sim/wb_memory_model.sv ====
/*
 wishbone classic slave memory for the testbench
 acks each strobe after 0 to 3 wait cycles from a galois LFSR,
 applies byte selects and counts bus reads and writes
*/
`timescale 1ns/1ps

module wb_memory_model #(
	parameter int unsigned WORDS = 1024,
	parameter logic [31:0] SEED = 32'h1
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input logic [31:0] i_wb_adr,
	input logic [31:0] i_wb_dat,
	input logic [3:0] i_wb_sel,
	output logic [31:0] o_wb_dat,
	output logic o_wb_ack
);

	localparam int unsigned WORD_BITS = $clog2(WORDS);

	logic [31:0] mem [WORDS];
	int read_count;
	int write_count;
	logic [31:0] last_adr;
	logic [3:0] last_sel;
	logic [31:0] last_dat;
	logic [31:0] lfsr;
	logic [1:0] delay;
	logic [1:0] wait_count;
	logic [WORD_BITS-1:0] word;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hd0000001;
		end
		return s >> 1;
	endfunction

	// every word distinct and built from its whole word address
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = {16'(i) ^ 16'hc3a5, 16'(i)};
		end
		read_count = 0;
		write_count = 0;
	end

	assign word = i_wb_adr[2 +: WORD_BITS];

	// responds on the falling edge so the master samples on the rising one
	always @(negedge i_clock) begin
		if (i_reset) begin
			o_wb_ack <= 1'b0;
			wait_count <= '0;
			delay <= '0;
			lfsr = SEED;
		end
		else if (o_wb_ack) begin
			o_wb_ack <= 1'b0;
		end
		else if (i_wb_cyc && i_wb_stb) begin
			if (wait_count != delay) begin
				wait_count <= wait_count + 1'b1;
			end
			else begin
				o_wb_ack <= 1'b1;
				wait_count <= '0;
				// next delay with one step per bit
				delay[0] <= lfsr[0];
				lfsr = lfsr_step(lfsr);
				delay[1] <= lfsr[0];
				lfsr = lfsr_step(lfsr);
				if (i_wb_we) begin
					for (int b = 0; b < 4; b++) begin
						if (i_wb_sel[b]) begin
							mem[word][b*8 +: 8] <= i_wb_dat[b*8 +: 8];
						end
					end
					write_count++;
					last_adr <= i_wb_adr;
					last_sel <= i_wb_sel;
					last_dat <= i_wb_dat;
				end
				else begin
					o_wb_dat <= mem[word];
					read_count++;
				end
			end
		end
	end

endmodule

// ==== sim/tb_dcache.sv ====
/*
 data cache testbench
 directed tests against a shadow of memory and of the expected
 line contents with bus traffic counted by the memory model
*/
`timescale 1ns/1ps

module tb_dcache;

	localparam int unsigned MEM_WORDS = 1024;
	localparam int unsigned MEM_ADDR_BITS = $clog2(MEM_WORDS);
	localparam logic [31:0] LFSR_SEED = 32'h759c;
	localparam int unsigned NUM_TESTS = 6;
	// each test may take a full flush at worst-case ack delay
	localparam int unsigned TIMEOUT_CYCLES = NUM_TESTS * (dcache_pkg::LINES * 8 + 200);

	logic clock;
	logic reset;
	logic request;
	logic rw;
	logic flush;
	logic cacheable;
	logic [31:0] address;
	logic [31:0] wdata;
	logic [3:0] wmask;
	logic ready;
	logic [31:0] rdata;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_out;
	logic [3:0] wb_sel;
	logic [31:0] wb_dat_in;
	logic wb_ack;

	// expected line contents and memory
	logic [dcache_pkg::TAG_BITS-1:0] exp_tag [dcache_pkg::LINES];
	logic [3:0] exp_mask [dcache_pkg::LINES];
	logic [31:0] exp_data [dcache_pkg::LINES];
	logic exp_dirty [dcache_pkg::LINES];
	logic [31:0] shadow [MEM_WORDS];
	int checks;
	int errors;
	int cycle_count;
	int reads_before;
	int writes_before;

	dcache_top i_dcache_top (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_rw(rw),
		.i_flush(flush),
		.i_cacheable(cacheable),
		.i_address(address),
		.i_wdata(wdata),
		.i_wmask(wmask),
		.o_ready(ready),
		.o_rdata(rdata),
		.o_wb_cyc(wb_cyc),
		.o_wb_stb(wb_stb),
		.o_wb_we(wb_we),
		.o_wb_adr(wb_adr),
		.o_wb_dat(wb_dat_out),
		.o_wb_sel(wb_sel),
		.i_wb_dat(wb_dat_in),
		.i_wb_ack(wb_ack)
	);

	wb_memory_model #(.WORDS(MEM_WORDS), .SEED(LFSR_SEED)) i_memory (
		.i_clock(clock),
		.i_reset(reset),
		.i_wb_cyc(wb_cyc),
		.i_wb_stb(wb_stb),
		.i_wb_we(wb_we),
		.i_wb_adr(wb_adr),
		.i_wb_dat(wb_dat_out),
		.i_wb_sel(wb_sel),
		.o_wb_dat(wb_dat_in),
		.o_wb_ack(wb_ack)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

	// ==============================
	// helpers
	// ==============================
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] sel);
		logic [31:0] word;
		word = old_word;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				word[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return word;
	endfunction

	function automatic int word_of(input logic [31:0] addr);
		return addr[2 +: MEM_ADDR_BITS];
	endfunction

	function automatic logic [dcache_pkg::TAG_BITS-1:0] tag_of(input logic [31:0] addr);
		return addr[31 -: dcache_pkg::TAG_BITS];
	endfunction

	function automatic logic [31:0] line_address(input int idx);
		logic [dcache_pkg::INDEX_BITS-1:0] index;
		index = idx;
		return {exp_tag[idx], index, 2'b00};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic mark_bus();
		reads_before = i_memory.read_count;
		writes_before = i_memory.write_count;
	endtask

	task automatic check_bus(input int reads, input int writes);
		check_value("bus reads", i_memory.read_count - reads_before, reads);
		check_value("bus writes", i_memory.write_count - writes_before, writes);
	endtask

	task automatic compare_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			check_value($sformatf("memory word %0d", i), i_memory.mem[i], shadow[i]);
		end
	endtask

	// dirty line goes to memory under its own byte mask
	task automatic write_back_line(input int idx);
		int w;
		w = word_of(line_address(idx));
		shadow[w] = merge_bytes(shadow[w], exp_data[idx], exp_mask[idx]);
		exp_dirty[idx] = 1'b0;
	endtask

	// starts and ends on a falling edge and counts cycles until ready
	task automatic issue(input logic write, input logic flush_req, input logic cached,
			input logic [31:0] addr, input logic [31:0] data, input logic [3:0] sel,
			output logic [31:0] got, output int cycles);
		request = 1'b1;
		rw = write;
		flush = flush_req;
		cacheable = cached;
		address = addr;
		wdata = data;
		wmask = sel;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!ready);
		got = rdata;
		@(negedge clock);
		request = 1'b0;
	endtask

	task automatic cached_read(input logic [31:0] addr);
		int idx;
		int cycles;
		logic hit;
		logic dirty_out;
		logic [31:0] got;
		idx = addr[2 +: dcache_pkg::INDEX_BITS];
		hit = exp_mask[idx] == 4'hf && exp_tag[idx] == tag_of(addr);
		dirty_out = !hit && exp_dirty[idx] && exp_mask[idx] != 0;
		mark_bus();
		if (dirty_out) begin
			write_back_line(idx);
		end
		if (!hit) begin
			exp_tag[idx] = tag_of(addr);
			exp_mask[idx] = 4'hf;
			exp_data[idx] = shadow[word_of(addr)];
			exp_dirty[idx] = 1'b0;
		end
		issue(1'b0, 1'b0, 1'b1, addr, '0, '0, got, cycles);
		check_value("o_rdata", got, exp_data[idx]);
		check_bus(!hit, dirty_out);
		if (hit) begin
			check_value("read hit latency", cycles, 1);
		end
	endtask

	task automatic cached_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] sel);
		int idx;
		int cycles;
		logic match;
		logic evict;
		logic [31:0] out_adr;
		logic [3:0] out_sel;
		logic [31:0] out_dat;
		logic [31:0] got;
		idx = addr[2 +: dcache_pkg::INDEX_BITS];
		match = exp_mask[idx] != 0 && exp_tag[idx] == tag_of(addr);
		evict = !match && exp_dirty[idx] && exp_mask[idx] != 0;
		out_adr = line_address(idx);
		out_sel = exp_mask[idx];
		out_dat = exp_data[idx];
		mark_bus();
		if (evict) begin
			write_back_line(idx);
		end
		if (match) begin
			exp_data[idx] = merge_bytes(exp_data[idx], data, sel);
			exp_mask[idx] = exp_mask[idx] | sel;
		end
		else begin
			exp_tag[idx] = tag_of(addr);
			exp_mask[idx] = sel;
			exp_data[idx] = data;
		end
		exp_dirty[idx] = 1'b1;
		issue(1'b1, 1'b0, 1'b1, addr, data, sel, got, cycles);
		check_bus(0, evict);
		if (evict) begin
			check_value("o_wb_adr", i_memory.last_adr, out_adr);
			check_value("o_wb_sel", i_memory.last_sel, out_sel);
			check_value("o_wb_dat", merge_bytes('0, i_memory.last_dat, out_sel),
				merge_bytes('0, out_dat, out_sel));
		end
		else begin
			check_value("write latency", cycles, 1);
		end
	endtask

	task automatic uncached_access(input logic write, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] sel);
		int cycles;
		logic [31:0] got;
		mark_bus();
		if (write) begin
			shadow[word_of(addr)] = merge_bytes(shadow[word_of(addr)], data, sel);
		end
		issue(write, 1'b0, 1'b0, addr, data, sel, got, cycles);
		check_bus(!write, write);
		if (write) begin
			check_value("memory after uncached write", i_memory.mem[word_of(addr)],
				shadow[word_of(addr)]);
		end
		else begin
			check_value("o_rdata", got, shadow[word_of(addr)]);
		end
	endtask

	task automatic flush_all();
		int dirty_lines;
		int cycles;
		logic [31:0] got;
		dirty_lines = 0;
		for (int i = 0; i < dcache_pkg::LINES; i++) begin
			if (exp_dirty[i] && exp_mask[i] != 0) begin
				write_back_line(i);
				dirty_lines++;
			end
		end
		mark_bus();
		issue(1'b0, 1'b1, 1'b1, '0, '0, '0, got, cycles);
		check_bus(0, dirty_lines);
	endtask

	task automatic report_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			$display("test %s: passed", name);
		end
		else begin
			$display("test %s: failed with %0d mismatches", name, errors - start_errors);
		end
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic reset_and_init();
		int start;
		start = errors;
		repeat (dcache_pkg::LINES + 1) begin
			@(negedge clock);
			check_value("o_wb_cyc", wb_cyc, 1'b0);
			check_value("o_wb_stb", wb_stb, 1'b0);
			check_value("o_ready", ready, 1'b0);
		end
		cached_read(32'h100);
		cached_read(32'h0f8);
		report_test("reset_init", start);
	endtask

	task automatic miss_then_hit();
		int start;
		start = errors;
		cached_read(32'h204);
		cached_read(32'h204);
		report_test("miss_then_hit", start);
	endtask

	task automatic masked_write_merge();
		int start;
		start = errors;
		cached_write(32'h308, 32'h1111_11aa, 4'b0001);
		cached_write(32'h308, 32'h22bb_2222, 4'b0100);
		// memory still holds the old word under write-back
		compare_memory();
		cached_read(32'h308);
		cached_write(32'h40c, 32'h3333_ccdd, 4'b0011);
		cached_write(32'h40c, 32'heeff_4444, 4'b1100);
		cached_read(32'h40c);
		report_test("masked_write", start);
	endtask

	task automatic conflict_eviction();
		int start;
		start = errors;
		cached_write(32'h510, 32'h5555_5555, 4'b0110);
		cached_write(32'h510, 32'h5a00_0000, 4'b1000);
		// same index with another tag
		cached_write(32'h910, 32'h9999_9999, 4'b1111);
		compare_memory();
		cached_read(32'hd10);
		compare_memory();
		report_test("conflict_eviction", start);
	endtask

	task automatic uncached_pass_through();
		int start;
		start = errors;
		cached_read(32'h614);
		uncached_access(1'b1, 32'ha14, 32'h0a0b_0c0d, 4'b1001);
		uncached_access(1'b0, 32'ha14, '0, '0);
		uncached_access(1'b0, 32'h614, '0, '0);
		cached_read(32'h614);
		report_test("uncached", start);
	endtask

	task automatic flush_dirty_lines();
		int start;
		start = errors;
		cached_write(32'h718, 32'h7777_1818, 4'b1111);
		cached_write(32'h71c, 32'h0000_1c00, 4'b0010);
		cached_write(32'hb20, 32'hb200_0000, 4'b1000);
		cached_read(32'h724);
		cached_read(32'h128);
		flush_all();
		compare_memory();
		flush_all();
		report_test("flush", start);
	endtask

	initial begin
		reset = 1'b1;
		request = 1'b0;
		rw = 1'b0;
		flush = 1'b0;
		cacheable = 1'b0;
		address = '0;
		wdata = '0;
		wmask = '0;
		checks = 0;
		errors = 0;
		for (int i = 0; i < dcache_pkg::LINES; i++) begin
			exp_tag[i] = '0;
			exp_mask[i] = '0;
			exp_data[i] = '0;
			exp_dirty[i] = 1'b0;
		end
		repeat (10) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = i_memory.mem[i];
		end
		reset_and_init();
		miss_then_hit();
		masked_write_merge();
		conflict_eviction();
		uncached_pass_through();
		flush_dirty_lines();
		$display("tests %0d, checks %0d, mismatches %0d", NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end
		else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== files.f ====
source/dcache_pkg.sv
source/cache_ram_if.sv
source/cache_ram.sv
source/dcache_controller.sv
source/dcache_top.sv
sim/wb_memory_model.sv
sim/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/cache_ram_if.sv
  - source/cache_ram.sv
  - source/dcache_controller.sv
  - source/dcache_top.sv
  - target: simulation
    files:
      - sim/wb_memory_model.sv
      - sim/tb_dcache.sv
